//--- rtl/fpsu_macros.svh
`ifndef FPSU_MACROS_SVH
`define FPSU_MACROS_SVH

// one half of a 128-bit operand, two packed singles
`define FPSU_HALF_W 64

// issue tag width, tags wrap modulo 16
`define FPSU_TAG_W 4

// result queue entries, equal to the issue credits handed out after reset
`define FPSU_QUEUE_DEPTH 4

// output credits the unit owns after reset
`define FPSU_OUT_CREDITS 2

`endif

//--- rtl/fpsu_pkg.sv
`include "fpsu_macros.svh"

package fpsu_pkg;

  typedef logic [`FPSU_HALF_W-1:0] half_t; // two packed singles
  typedef logic [`FPSU_TAG_W-1:0]  tag_t;
  typedef logic [3:0]              op_t;
  typedef logic [1:0]              src_t;
  typedef logic [2:0]              func_t;
  typedef logic [1:0]              ret_t;

  // opcodes, 10 and up are illegal
  localparam op_t OP_AND    = 4'd0;
  localparam op_t OP_OR     = 4'd1;
  localparam op_t OP_XOR    = 4'd2;
  localparam op_t OP_ANDN   = 4'd3;
  localparam op_t OP_MOVA   = 4'd4;
  localparam op_t OP_FNEG   = 4'd5;
  localparam op_t OP_FABS   = 4'd6;
  localparam op_t OP_SWAP   = 4'd7;
  localparam op_t OP_UNPKLO = 4'd8;
  localparam op_t OP_UNPKHI = 4'd9;

  localparam src_t SRC_REG  = 2'd0;
  localparam src_t SRC_FWD0 = 2'd1; // forwarding bus entry 0
  localparam src_t SRC_FWD1 = 2'd2;
  localparam src_t SRC_ZERO = 2'd3;

  localparam func_t F_PASS = 3'd0;
  localparam func_t F_AND  = 3'd1;
  localparam func_t F_OR   = 3'd2;
  localparam func_t F_XOR  = 3'd3;
  localparam func_t F_ANDN = 3'd4; // x and not y
  localparam func_t F_NEG  = 3'd5;
  localparam func_t F_ABS  = 3'd6;

  // return code bit positions
  localparam int RET_ZERO    = 0;
  localparam int RET_ILLEGAL = 1;

  // sign bits of both singles in a half
  localparam half_t SIGN_MASK = 64'h8000_0000_8000_0000;

endpackage

//--- rtl/fpsu_decode.sv
`timescale 1ns/1ps

module fpsu_decode import fpsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  op_t   in_op,
  input  tag_t  in_tag,
  input  src_t  in_src_a,
  input  src_t  in_src_b,
  input  half_t in_a_hi,
  input  half_t in_a_lo,
  input  half_t in_b_hi,
  input  half_t in_b_lo,
  input  half_t fwd0_hi,
  input  half_t fwd0_lo,
  input  half_t fwd1_hi,
  input  half_t fwd1_lo,
  output logic  dec_valid,
  output tag_t  dec_tag,
  output logic  dec_illegal,
  output func_t dec_func,
  output half_t hi_x,
  output half_t hi_y,
  output half_t lo_x,
  output half_t lo_y
);

  half_t a_hi, a_lo, b_hi, b_lo;
  half_t nx_hi_x, nx_hi_y, nx_lo_x, nx_lo_y;
  func_t nx_func;
  logic  illegal;

  function automatic half_t pick(input src_t s, input half_t r, input half_t f0,
                                 input half_t f1);
    case (s)
      SRC_REG:  pick = r;
      SRC_FWD0: pick = f0;
      SRC_FWD1: pick = f1;
      SRC_ZERO: pick = '0;
      default:  pick = '0;
    endcase
  endfunction

  assign a_hi = pick(in_src_a, in_a_hi, fwd0_hi, fwd1_hi);
  assign a_lo = pick(in_src_a, in_a_lo, fwd0_lo, fwd1_lo);
  assign b_hi = pick(in_src_b, in_b_hi, fwd0_hi, fwd1_hi);
  assign b_lo = pick(in_src_b, in_b_lo, fwd0_lo, fwd1_lo);

  assign illegal = (in_op > OP_UNPKHI);

  always_comb begin
    nx_func = F_PASS;
    nx_hi_x = a_hi;
    nx_hi_y = b_hi;
    nx_lo_x = a_lo;
    nx_lo_y = b_lo;
    case (in_op)
      OP_AND:  nx_func = F_AND;
      OP_OR:   nx_func = F_OR;
      OP_XOR:  nx_func = F_XOR;
      OP_ANDN: nx_func = F_ANDN;
      OP_MOVA: nx_func = F_PASS;
      OP_FNEG: nx_func = F_NEG;
      OP_FABS: nx_func = F_ABS;
      OP_SWAP: begin // halves cross between the slices
        nx_hi_x = a_lo;
        nx_lo_x = a_hi;
      end
      OP_UNPKLO: begin
        nx_hi_x = b_lo;
        nx_lo_x = a_lo;
      end
      OP_UNPKHI: begin
        nx_hi_x = b_hi;
        nx_lo_x = a_hi;
      end
      default: begin // illegal, both slices see zero
        nx_hi_x = '0;
        nx_hi_y = '0;
        nx_lo_x = '0;
        nx_lo_y = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec_tag     <= in_tag;
      dec_illegal <= illegal;
      dec_func    <= nx_func;
      hi_x        <= nx_hi_x;
      hi_y        <= nx_hi_y;
      lo_x        <= nx_lo_x;
      lo_y        <= nx_lo_y;
    end
  end

endmodule

//--- rtl/fpsu_execute.sv
`timescale 1ns/1ps

module fpsu_execute import fpsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  dec_valid,
  input  func_t dec_func,
  input  half_t x,
  input  half_t y,
  output logic  exe_valid,
  output half_t exe_data,
  output logic  exe_zero
);

  // one 64-bit slice, the unit runs a high and a low copy side by side
  half_t f;

  always_comb begin
    case (dec_func)
      F_PASS: begin
        f = x;
      end
      F_AND: begin
        f = x & y;
      end
      F_OR: begin
        f = x | y;
      end
      F_XOR: begin
        f = x ^ y;
      end
      F_ANDN: begin
        f = x & ~y;
      end
      F_NEG: begin
        f = x ^ SIGN_MASK; // flip both single signs
      end
      F_ABS: begin
        f = x & ~SIGN_MASK;
      end
      default: begin
        f = x;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      exe_data <= f;
      exe_zero <= (f == '0); // per-half flag, merged in the result stage
    end
  end

endmodule

//--- rtl/fpsu_result.sv
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_result import fpsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  hi_valid,
  input  half_t hi_data,
  input  logic  hi_zero,
  input  logic  lo_valid,
  input  half_t lo_data,
  input  logic  lo_zero,
  input  tag_t  exe_tag,
  input  logic  exe_illegal,
  input  logic  out_credit_ret,
  output logic  res_valid,
  output half_t res_hi,
  output half_t res_lo,
  output tag_t  res_tag,
  output ret_t  res_ret,
  output logic  credit_ret
);

  localparam int DEPTH = `FPSU_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH); // depth is a power of two, pointers wrap
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`FPSU_OUT_CREDITS + 1);

  half_t            q_hi  [DEPTH];
  half_t            q_lo  [DEPTH];
  tag_t             q_tag [DEPTH];
  ret_t             q_ret [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] out_cred;
  tag_t             tag_q;
  logic             illegal_q;
  ret_t             ret_in;
  logic             push;
  logic             pop;

  // decode sideband skips the slices, one register brings it level with them
  always_ff @(posedge clk) begin
    tag_q     <= exe_tag;
    illegal_q <= exe_illegal;
  end

  assign push = hi_valid & lo_valid;
  assign pop  = (count != '0) && (out_cred != '0); // one result per cycle at most

  always_comb begin
    ret_in              = '0;
    ret_in[RET_ZERO]    = hi_zero & lo_zero; // zero only if both halves are
    ret_in[RET_ILLEGAL] = illegal_q;
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_hi[wr_ptr]  <= hi_data;
      q_lo[wr_ptr]  <= lo_data;
      q_tag[wr_ptr] <= tag_q;
      q_ret[wr_ptr] <= ret_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      out_cred   <= CRD_W'(`FPSU_OUT_CREDITS);
      credit_ret <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + CNT_W'(push) - CNT_W'(pop);
      out_cred   <= out_cred + CRD_W'(out_credit_ret) - CRD_W'(pop);
      credit_ret <= pop; // slot freed, hand the issue credit back
    end
  end

  assign res_valid = pop;
  assign res_hi    = q_hi[rd_ptr];
  assign res_lo    = q_lo[rd_ptr];
  assign res_tag   = q_tag[rd_ptr];
  assign res_ret   = q_ret[rd_ptr];

endmodule

//--- rtl/fpsu_top.sv
`timescale 1ns/1ps

module fpsu_top import fpsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  op_t   in_op,
  input  tag_t  in_tag,
  input  src_t  in_src_a,
  input  src_t  in_src_b,
  input  half_t in_a_hi,
  input  half_t in_a_lo,
  input  half_t in_b_hi,
  input  half_t in_b_lo,
  input  half_t fwd0_hi,
  input  half_t fwd0_lo,
  input  half_t fwd1_hi,
  input  half_t fwd1_lo,
  output logic  credit_ret,
  output logic  res_valid,
  output half_t res_hi,
  output half_t res_lo,
  output tag_t  res_tag,
  output ret_t  res_ret,
  input  logic  out_credit_ret
);

  logic  dec_valid;
  tag_t  dec_tag;
  logic  dec_illegal;
  func_t dec_func;
  half_t hi_x, hi_y, lo_x, lo_y;
  logic  hi_valid, lo_valid;
  half_t hi_data, lo_data;
  logic  hi_zero, lo_zero;

  fpsu_decode u_decode (
    .clk, .rst_n, .in_valid, .in_op, .in_tag, .in_src_a, .in_src_b,
    .in_a_hi, .in_a_lo, .in_b_hi, .in_b_lo,
    .fwd0_hi, .fwd0_lo, .fwd1_hi, .fwd1_lo,
    .dec_valid, .dec_tag, .dec_illegal, .dec_func,
    .hi_x, .hi_y, .lo_x, .lo_y
  );

  fpsu_execute u_exec_hi ( // bits 127:64
    .clk, .rst_n, .dec_valid, .dec_func,
    .x(hi_x), .y(hi_y),
    .exe_valid(hi_valid), .exe_data(hi_data), .exe_zero(hi_zero)
  );

  fpsu_execute u_exec_lo (
    .clk, .rst_n, .dec_valid, .dec_func,
    .x(lo_x), .y(lo_y),
    .exe_valid(lo_valid), .exe_data(lo_data), .exe_zero(lo_zero)
  );

  fpsu_result u_result (
    .clk, .rst_n,
    .hi_valid, .hi_data, .hi_zero,
    .lo_valid, .lo_data, .lo_zero,
    .exe_tag(dec_tag), .exe_illegal(dec_illegal), // delayed inside result
    .out_credit_ret,
    .res_valid, .res_hi, .res_lo, .res_tag, .res_ret, .credit_ret
  );

endmodule

//--- verif/fpsu_asserts.sv
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_asserts import fpsu_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  in_valid,
  input logic  credit_ret,
  input logic  res_valid,
  input logic  out_credit_ret,
  input ret_t  res_ret,
  input half_t res_hi,
  input half_t res_lo
);

  int issue_cnt; // credits still held by the issuer
  int out_cnt;   // output credits still held by the unit

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt <= `FPSU_QUEUE_DEPTH;
      out_cnt   <= `FPSU_OUT_CREDITS;
    end else begin
      issue_cnt <= issue_cnt - int'(in_valid) + int'(credit_ret);
      out_cnt   <= out_cnt + int'(out_credit_ret) - int'(res_valid);
    end
  end

  issue_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> issue_cnt > 0)
    else $error("issue seen while the issuer held no credit");

  result_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> out_cnt > 0)
    else $error("res_valid seen with no output credit left");

  illegal_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ret[RET_ILLEGAL]) |-> (res_hi == '0 && res_lo == '0))
    else $error("illegal opcode returned nonzero data");

endmodule

bind fpsu_top fpsu_asserts u_fpsu_asserts (
  .clk(clk),
  .rst_n(rst_n),
  .in_valid(in_valid),
  .credit_ret(credit_ret),
  .res_valid(res_valid),
  .out_credit_ret(out_credit_ret),
  .res_ret(res_ret),
  .res_hi(res_hi),
  .res_lo(res_lo)
);

//--- verif/fpsu_tb.sv
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_tb import fpsu_pkg::*; ();

  localparam int MAX_CASES = 64;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  op_t   in_op;
  tag_t  in_tag;
  src_t  in_src_a;
  src_t  in_src_b;
  half_t in_a_hi, in_a_lo, in_b_hi, in_b_lo;
  half_t fwd0_hi, fwd0_lo, fwd1_hi, fwd1_lo;
  logic  credit_ret;
  logic  res_valid;
  half_t res_hi, res_lo;
  tag_t  res_tag;
  ret_t  res_ret;
  logic  out_credit_ret;

  // columns 0..10 are stimulus and 11..13 the expected hi, lo and ret
  logic [63:0] cases [MAX_CASES][14];

  int          n_cases;
  int          n_issued;
  int          n_recv;
  int          n_cred_seen;
  int          issue_cred; // issue credits held by the bench
  int          owed;       // output credits the consumer still has to return
  int          cycles;
  int          limit;
  int          n_mismatch;
  int          n_other;
  logic        running;
  logic        loaded;
  logic [31:0] lfsr;

  fpsu_top u_fpsu_top (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
    end
    return n;
  endfunction

  task automatic load_cases();
    int          fd;
    int          r;
    string       line;
    logic [63:0] v [14];
    fd = $fopen("verif/fpsu_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file verif/fpsu_cases.txt");
      n_other++;
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      r = $fgets(line, fd);
      if (r > 1 && line.getc(0) != "#") begin
        r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                    v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
        if (r == 14) begin
          cases[n_cases] = v;
          n_cases++;
        end else begin
          $display("case file line could not be parsed: %s", line);
          n_other++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_case(input int idx);
    in_valid <= 1'b1;
    in_op    <= op_t'(cases[idx][0]);
    in_src_a <= src_t'(cases[idx][1]);
    in_src_b <= src_t'(cases[idx][2]);
    in_a_hi  <= cases[idx][3];
    in_a_lo  <= cases[idx][4];
    in_b_hi  <= cases[idx][5];
    in_b_lo  <= cases[idx][6];
    fwd0_hi  <= cases[idx][7];
    fwd0_lo  <= cases[idx][8];
    fwd1_hi  <= cases[idx][9];
    fwd1_lo  <= cases[idx][10];
    in_tag   <= tag_t'(idx); // tags wrap modulo 16
  endtask

  task automatic check_result(input int idx);
    if (res_tag !== tag_t'(idx)) begin
      $display("MISMATCH @%0t: case %0d tag %0d, expected %0d", $time, idx, res_tag,
               tag_t'(idx));
      n_mismatch++;
    end
    if (res_hi !== cases[idx][11]) begin
      $display("MISMATCH @%0t: case %0d hi %h, expected %h", $time, idx, res_hi,
               cases[idx][11]);
      n_mismatch++;
    end
    if (res_lo !== cases[idx][12]) begin
      $display("MISMATCH @%0t: case %0d lo %h, expected %h", $time, idx, res_lo,
               cases[idx][12]);
      n_mismatch++;
    end
    if (res_ret !== ret_t'(cases[idx][13])) begin
      $display("MISMATCH @%0t: case %0d ret %0d, expected %0d", $time, idx, res_ret,
               ret_t'(cases[idx][13]));
      n_mismatch++;
    end
  endtask

  task automatic report_counts();
    $display("results %0d of %0d, mismatches %0d, other errors %0d",
             n_recv, n_cases, n_mismatch, n_other);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (running) begin
      if (credit_ret) begin
        issue_cred++;
        n_cred_seen++;
      end
      if (res_valid) begin
        if (n_recv < n_issued) begin
          check_result(n_recv); // results must leave in issue order
        end else begin
          $display("a result arrived at %0t with no operation outstanding", $time);
          n_other++;
        end
        n_recv++;
        owed++;
      end
      out_credit_ret <= 1'b0;
      lfsr = lfsr_next(lfsr);
      if (owed > 0 && lfsr[0]) begin
        out_credit_ret <= 1'b1;
        owed--;
      end
      in_valid <= 1'b0;
      lfsr = lfsr_next(lfsr);
      if (n_issued < n_cases && issue_cred > 0 && lfsr[0]) begin
        issue_case(n_issued);
        issue_cred--;
        n_issued++;
      end
    end
  end

  initial begin
    in_valid       = 1'b0;
    in_op          = '0;
    in_tag         = '0;
    in_src_a       = '0;
    in_src_b       = '0;
    in_a_hi        = '0;
    in_a_lo        = '0;
    in_b_hi        = '0;
    in_b_lo        = '0;
    fwd0_hi        = '0;
    fwd0_lo        = '0;
    fwd1_hi        = '0;
    fwd1_lo        = '0;
    out_credit_ret = 1'b0;
    rst_n          = 1'b0;
    running        = 1'b0;
    loaded         = 1'b0;
    lfsr           = 32'hdb71_a3da;
    n_cases        = 0;
    n_issued       = 0;
    n_recv         = 0;
    n_cred_seen    = 0;
    owed           = 0;
    cycles         = 0;
    n_mismatch     = 0;
    n_other        = 0;
    issue_cred     = `FPSU_QUEUE_DEPTH;
    load_cases();
    limit  = 20 * n_cases + 100;
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    rst_n   <= 1'b1;
    running <= 1'b1;
    if (n_cases == 0) begin
      $display("no cases were loaded, nothing was tested");
      n_other++;
    end else begin
      wait (n_recv >= n_cases);
      repeat (4) @(posedge clk); // last credit_ret pulse trails its pop
    end
    if (n_cred_seen != n_issued) begin
      $display("%0d credit returns seen for %0d issues", n_cred_seen, n_issued);
      n_other++;
    end
    report_counts();
    if (n_mismatch + n_other == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    while (cycles < limit) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles, %0d of %0d results received", cycles, n_recv,
             n_cases);
    n_other++;
    report_counts();
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verif/fpsu_cases.txt
# op src_a src_b a_hi a_lo b_hi b_lo fwd0_hi fwd0_lo fwd1_hi fwd1_lo, all hex
# then the expected res_hi res_lo res_ret
0 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 010045008900cd00 0e0c0a0806040200 0
1 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 ff23ff67ffabffef ffdfbf9f7f5f3f1f 0
2 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 fe23ba6776ab32ef f1d3b597795b3d1f 0
3 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0023006700ab00ef f0d0b09070503010 0
4 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0123456789abcdef fedcba9876543210 0
5 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 8123456709abcdef 7edcba98f6543210 0
6 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0123456709abcdef 7edcba9876543210 0
7 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 fedcba9876543210 0123456789abcdef 0
8 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0f0f0f0f0f0f0f0f fedcba9876543210 0
9 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 ff00ff00ff00ff00 0123456789abcdef 0
4 1 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 1111111111111111 2222222222222222 0
4 2 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3333333333333333 4444444444444444 0
4 3 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
1 1 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3333333333333333 6666666666666666 0
2 1 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 2222222222222222 6666666666666666 0
0 2 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3300330033003300 0404040404040404 0
0 0 3 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
3 0 3 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0123456789abcdef fedcba9876543210 0
3 3 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
2 1 1 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
8 1 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 4444444444444444 2222222222222222 0
9 3 1 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 1111111111111111 0 0
7 2 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 4444444444444444 3333333333333333 0
5 3 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 8000000080000000 8000000080000000 0
6 1 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 1111111111111111 2222222222222222 0
5 2 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 b3333333b3333333 c4444444c4444444 0
9 0 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3333333333333333 0123456789abcdef 0
8 3 3 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
1 3 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 3333333333333333 4444444444444444 0
5 0 0 8000000080000000 8000000080000000 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
6 0 0 8000000080000000 8000000080000000 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 1
0 0 0 00ff00ff00ff00ff fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0e0c0a0806040200 0
2 0 0 0123456789abcdef 0f0f0f0f0f0f0f0f ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 fe23ba6776ab32ef 0 0
6 0 0 ffffffffffffffff ffffffffffffffff ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 7fffffff7fffffff 7fffffff7fffffff 0
5 0 0 7fffffff7fffffff 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 ffffffffffffffff 8000000080000000 0
a 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
b 1 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
c 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
d 3 3 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
e 2 1 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
f 0 0 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 0 0 3
1 0 1 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 1133557799bbddff fefebaba76763232 0
2 0 2 0123456789abcdef fedcba9876543210 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 1111111111111111 2222222222222222 3333333333333333 4444444444444444 32107654ba98fedc ba98fedc32107654 0

//--- compile.f
+incdir+rtl
rtl/fpsu_pkg.sv
rtl/fpsu_decode.sv
rtl/fpsu_execute.sv
rtl/fpsu_result.sv
rtl/fpsu_top.sv
verif/fpsu_asserts.sv
verif/fpsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fpsu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module fpsu_tb \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vfpsu_tb 2>&1)
echo "$out"
echo "$out" | grep -qF '** PASS **' && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
